/* files.f */
hw/ooo_pkg.sv
hw/inst_queue.sv
hw/dispatch_unit.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/rob.sv
hw/arch_regfile.sv
hw/cpu_top.sv
tests/tb_clock.sv
tests/tb_cpu_top.sv

/* hw/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  ooo_pkg::exec_req_t req,
    output ooo_pkg::wb_t       wb
);

    ooo_pkg::word_t    result;
    logic              lt;
    logic              valid_q;
    ooo_pkg::rob_tag_t tag_q;
    ooo_pkg::word_t    value_q;

    assign lt = ($signed(req.a) < $signed(req.b));   // slt is signed

    always_comb begin
        case (req.op)
            ooo_pkg::ALU_ADD: result = req.a + req.b;
            ooo_pkg::ALU_SUB: result = req.a - req.b;
            ooo_pkg::ALU_AND: result = req.a & req.b;
            ooo_pkg::ALU_OR:  result = req.a | req.b;
            ooo_pkg::ALU_XOR: result = req.a ^ req.b;
            ooo_pkg::ALU_SLT: result = {{(ooo_pkg::XLEN-1){1'b0}}, lt};
            ooo_pkg::ALU_SLL: result = req.a << req.b[4:0];
            ooo_pkg::ALU_SRL: result = req.a >> req.b[4:0];
            default:          result = req.a + req.b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) valid_q <= 1'b0;
        else valid_q <= req.valid;
    end

    always_ff @(posedge clk) begin
        tag_q   <= req.tag;
        value_q <= result;
    end

    assign wb = '{valid: valid_q, tag: tag_q, value: value_q};

endmodule

/* hw/arch_regfile.sv */
`timescale 1ns/1ps

module arch_regfile (
    input  logic             clk,
    input  logic             arst_n,
    input  ooo_pkg::areg_t   rs1,
    input  ooo_pkg::areg_t   rs2,
    output ooo_pkg::word_t   rdata1,
    output ooo_pkg::word_t   rdata2,
    input  ooo_pkg::commit_t commit
);

    ooo_pkg::word_t regs [ooo_pkg::NUM_AREGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < ooo_pkg::NUM_AREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && commit.rd != '0) begin   // x0 stays zero
            regs[commit.rd] <= commit.value;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             inst_valid,
    input  ooo_pkg::inst_t   inst,
    output logic             credit_return,
    output ooo_pkg::commit_t commit
);

    logic                head_valid;
    ooo_pkg::inst_t      head;
    logic                pop;
    ooo_pkg::rob_alloc_t alloc;
    logic                alloc_ready;
    ooo_pkg::rob_tag_t   alloc_tag;
    ooo_pkg::rob_tag_t   src1_tag;
    ooo_pkg::rob_tag_t   src2_tag;
    logic                src1_ready;
    logic                src2_ready;
    ooo_pkg::word_t      src1_value;
    ooo_pkg::word_t      src2_value;
    ooo_pkg::areg_t      rs1;
    ooo_pkg::areg_t      rs2;
    ooo_pkg::word_t      rdata1;
    ooo_pkg::word_t      rdata2;
    ooo_pkg::exec_req_t  alu_req;
    ooo_pkg::exec_req_t  mul_req;
    ooo_pkg::wb_t        alu_wb;
    ooo_pkg::wb_t        mul_wb;

    inst_queue i_inst_queue (
        .clk           (clk),
        .arst_n        (arst_n),
        .push          (inst_valid),
        .push_inst     (inst),
        .pop           (pop),
        .head_valid    (head_valid),
        .head          (head),
        .credit_return (credit_return)
    );

    dispatch_unit i_dispatch_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .head_valid  (head_valid),
        .head        (head),
        .pop         (pop),
        .alloc       (alloc),
        .alloc_ready (alloc_ready),
        .alloc_tag   (alloc_tag),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .src1_ready  (src1_ready),
        .src2_ready  (src2_ready),
        .src1_value  (src1_value),
        .src2_value  (src2_value),
        .rs1         (rs1),
        .rs2         (rs2),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .alu_req     (alu_req),
        .mul_req     (mul_req),
        .commit      (commit)
    );

    alu_unit i_alu_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (alu_req),
        .wb     (alu_wb)
    );

    mul_unit i_mul_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (mul_req),
        .wb     (mul_wb)
    );

    rob i_rob (
        .clk         (clk),
        .arst_n      (arst_n),
        .alloc       (alloc),
        .alloc_ready (alloc_ready),
        .alloc_tag   (alloc_tag),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .src1_ready  (src1_ready),
        .src2_ready  (src2_ready),
        .src1_value  (src1_value),
        .src2_value  (src2_value),
        .alu_wb      (alu_wb),
        .mul_wb      (mul_wb),
        .commit      (commit)
    );

    arch_regfile i_arch_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .commit (commit)
    );

endmodule

/* hw/dispatch_unit.sv */
`timescale 1ns/1ps

module dispatch_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                head_valid,
    input  ooo_pkg::inst_t      head,
    output logic                pop,
    output ooo_pkg::rob_alloc_t alloc,
    input  logic                alloc_ready,
    input  ooo_pkg::rob_tag_t   alloc_tag,
    output ooo_pkg::rob_tag_t   src1_tag,
    output ooo_pkg::rob_tag_t   src2_tag,
    input  logic                src1_ready,
    input  logic                src2_ready,
    input  ooo_pkg::word_t      src1_value,
    input  ooo_pkg::word_t      src2_value,
    output ooo_pkg::areg_t      rs1,
    output ooo_pkg::areg_t      rs2,
    input  ooo_pkg::word_t      rdata1,
    input  ooo_pkg::word_t      rdata2,
    output ooo_pkg::exec_req_t  alu_req,
    output ooo_pkg::exec_req_t  mul_req,
    input  ooo_pkg::commit_t    commit
);

    logic [6:0]                      opcode;
    logic [2:0]                      funct3;
    logic [6:0]                      funct7;
    logic                            dec_ok;
    logic                            dec_mul;
    logic                            dec_imm;
    ooo_pkg::alu_op_e                dec_op;
    ooo_pkg::areg_t                  dec_rd;
    ooo_pkg::word_t                  imm;
    logic [ooo_pkg::NUM_AREGS-1:0]   ren_busy;
    ooo_pkg::rob_tag_t               ren_tag [ooo_pkg::NUM_AREGS];
    ooo_pkg::rob_tag_t               retire_tag;   // tag of the next commit
    logic                            busy1;
    logic                            busy2;
    ooo_pkg::word_t                  opa;
    ooo_pkg::word_t                  opb;
    logic                            fire;

    assign opcode = head[6:0];
    assign funct3 = head[14:12];
    assign funct7 = head[31:25];
    assign imm    = {{(ooo_pkg::XLEN-12){head[31]}}, head[31:20]};

    always_comb begin
        dec_ok  = 1'b1;
        dec_mul = 1'b0;
        dec_imm = 1'b0;
        dec_op  = ooo_pkg::ALU_ADD;
        if (opcode == ooo_pkg::OPC_OP_IMM && funct3 == 3'b000) begin
            dec_imm = 1'b1;   // addi
        end else if (opcode == ooo_pkg::OPC_OP) begin
            case ({funct7, funct3})
                {7'b0000000, 3'b000}:             dec_op = ooo_pkg::ALU_ADD;
                {ooo_pkg::FUNCT7_ALT, 3'b000}:    dec_op = ooo_pkg::ALU_SUB;
                {7'b0000000, 3'b111}:             dec_op = ooo_pkg::ALU_AND;
                {7'b0000000, 3'b110}:             dec_op = ooo_pkg::ALU_OR;
                {7'b0000000, 3'b100}:             dec_op = ooo_pkg::ALU_XOR;
                {7'b0000000, 3'b010}:             dec_op = ooo_pkg::ALU_SLT;
                {7'b0000000, 3'b001}:             dec_op = ooo_pkg::ALU_SLL;
                {7'b0000000, 3'b101}:             dec_op = ooo_pkg::ALU_SRL;
                {ooo_pkg::FUNCT7_MULDIV, 3'b000}: dec_mul = 1'b1;
                default:                          dec_ok = 1'b0;
            endcase
        end else begin
            dec_ok = 1'b0;
        end
    end

    // anything unknown becomes add x0, x0, x0
    assign dec_rd = dec_ok ? head[11:7] : '0;
    assign rs1    = dec_ok ? head[19:15] : '0;
    assign rs2    = (dec_ok && !dec_imm) ? head[24:20] : '0;

    assign busy1    = ren_busy[rs1];
    assign busy2    = ren_busy[rs2];
    assign src1_tag = ren_tag[rs1];
    assign src2_tag = ren_tag[rs2];

    assign opa = busy1 ? src1_value : rdata1;
    assign opb = dec_imm ? imm : (busy2 ? src2_value : rdata2);

    // in-order stall until both sources can be read
    assign fire = head_valid && alloc_ready && (!busy1 || src1_ready) && (!busy2 || src2_ready);
    assign pop  = fire;

    assign alloc   = '{valid: fire, rd: dec_rd};
    assign alu_req = '{valid: fire && !dec_mul, tag: alloc_tag, op: dec_op, a: opa, b: opb};
    assign mul_req = '{valid: fire && dec_mul, tag: alloc_tag, op: dec_op, a: opa, b: opb};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ren_busy   <= '0;
            retire_tag <= '0;
        end else begin
            if (commit.valid) begin
                retire_tag <= retire_tag + 1'b1;
                if (ren_tag[commit.rd] == retire_tag) ren_busy[commit.rd] <= 1'b0;
            end
            // a new rename wins over a clear in the same cycle
            if (fire && dec_rd != '0) ren_busy[dec_rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) ren_tag[dec_rd] <= alloc_tag;
    end

endmodule

/* hw/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           push,
    input  ooo_pkg::inst_t push_inst,
    input  logic           pop,
    output logic           head_valid,
    output ooo_pkg::inst_t head,
    output logic           credit_return
);

    typedef logic [$clog2(ooo_pkg::IQ_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(ooo_pkg::IQ_DEPTH+1)-1:0] count_t;

    ooo_pkg::inst_t mem [ooo_pkg::IQ_DEPTH];
    ptr_t           rd_ptr;
    ptr_t           wr_ptr;
    count_t         count;
    logic           full;

    assign full          = (count == count_t'(ooo_pkg::IQ_DEPTH));
    assign head_valid    = (count != '0);
    assign head          = mem[rd_ptr];
    assign credit_return = pop;   // slot freed, credit back to the source

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_inst;
    end

    // source overran its credits
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> (!full || pop));

endmodule

/* hw/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  ooo_pkg::exec_req_t req,
    output ooo_pkg::wb_t       wb
);

    localparam int S = ooo_pkg::MUL_STAGES;

    logic [S-1:0]      vld_q;
    ooo_pkg::rob_tag_t tag_q  [S];
    ooo_pkg::word_t    prod_q [S];
    ooo_pkg::word_t    a_q;
    logic [15:0]       bhi_q;   // upper half of b, used in stage 1

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) vld_q <= '0;
        else vld_q <= {vld_q[S-2:0], req.valid};
    end

    always_ff @(posedge clk) begin
        // stage 0 multiplies by the low half of b
        tag_q[0]  <= req.tag;
        prod_q[0] <= req.a * {{(ooo_pkg::XLEN-16){1'b0}}, req.b[15:0]};
        a_q       <= req.a;
        bhi_q     <= req.b[31:16];

        // stage 1 adds the high half, only the low 32 bits survive
        tag_q[1]  <= tag_q[0];
        prod_q[1] <= prod_q[0] + ((a_q * {{(ooo_pkg::XLEN-16){1'b0}}, bhi_q}) << 16);

        for (int i = 2; i < S; i++) begin
            tag_q[i]  <= tag_q[i-1];
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign wb = '{valid: vld_q[S-1], tag: tag_q[S-1], value: prod_q[S-1]};

endmodule

/* hw/ooo_pkg.sv */
package ooo_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_AREGS  = 32;
    localparam int IQ_DEPTH   = 4;   // also the credit count after reset
    localparam int ROB_DEPTH  = 8;
    localparam int MUL_STAGES = 3;

    // rv32 encodings seen by decode
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [31:0]                  inst_t;
    typedef logic [4:0]                   areg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    // issue to alu or multiplier
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        alu_op_e  op;
        word_t    a;
        word_t    b;
    } exec_req_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } wb_t;

    typedef struct packed {
        logic  valid;
        areg_t rd;
    } rob_alloc_t;

    typedef struct packed {
        logic  valid;
        areg_t rd;
        word_t value;
    } commit_t;

endpackage

/* hw/rob.sv */
`timescale 1ns/1ps

module rob (
    input  logic                clk,
    input  logic                arst_n,
    input  ooo_pkg::rob_alloc_t alloc,
    output logic                alloc_ready,
    output ooo_pkg::rob_tag_t   alloc_tag,
    input  ooo_pkg::rob_tag_t   src1_tag,
    input  ooo_pkg::rob_tag_t   src2_tag,
    output logic                src1_ready,
    output logic                src2_ready,
    output ooo_pkg::word_t      src1_value,
    output ooo_pkg::word_t      src2_value,
    input  ooo_pkg::wb_t        alu_wb,
    input  ooo_pkg::wb_t        mul_wb,
    output ooo_pkg::commit_t    commit
);

    typedef logic [$clog2(ooo_pkg::ROB_DEPTH+1)-1:0] count_t;

    logic [ooo_pkg::ROB_DEPTH-1:0] busy;
    logic [ooo_pkg::ROB_DEPTH-1:0] ready;
    ooo_pkg::areg_t                rd    [ooo_pkg::ROB_DEPTH];
    ooo_pkg::word_t                value [ooo_pkg::ROB_DEPTH];
    ooo_pkg::rob_tag_t             head;
    ooo_pkg::rob_tag_t             tail;
    count_t                        count;
    logic                          retire;
    logic                          commit_valid;
    ooo_pkg::areg_t                commit_rd;
    ooo_pkg::word_t                commit_value;

    assign alloc_ready = (count != count_t'(ooo_pkg::ROB_DEPTH));
    assign alloc_tag   = tail;

    // ready stays set after retirement so a lookup in the commit cycle still hits
    assign src1_ready = ready[src1_tag];
    assign src2_ready = ready[src2_tag];
    assign src1_value = value[src1_tag];
    assign src2_value = value[src2_tag];

    assign retire = busy[head] && ready[head];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy         <= '0;
            ready        <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (alloc.valid) begin
                busy[tail]  <= 1'b1;
                ready[tail] <= 1'b0;
                tail        <= tail + 1'b1;
            end
            if (alu_wb.valid) ready[alu_wb.tag] <= 1'b1;
            if (mul_wb.valid) ready[mul_wb.tag] <= 1'b1;
            if (retire) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            commit_valid <= retire;
            case ({alloc.valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.valid) rd[tail] <= alloc.rd;
        if (alu_wb.valid) value[alu_wb.tag] <= alu_wb.value;
        if (mul_wb.valid) value[mul_wb.tag] <= mul_wb.value;
        if (retire) begin
            commit_rd    <= rd[head];
            commit_value <= value[head];
        end
    end

    assign commit = '{valid: commit_valid, rd: commit_rd, value: commit_value};

    // a result must land on an entry allocated by dispatch
    a_alu_wb_busy: assert property (@(posedge clk) disable iff (!arst_n)
        alu_wb.valid |-> busy[alu_wb.tag]);
    a_mul_wb_busy: assert property (@(posedge clk) disable iff (!arst_n)
        mul_wb.valid |-> busy[mul_wb.tag]);

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f files.f --top-module tb_cpu_top -o sim_tb_cpu_top

out=$(./obj_dir/sim_tb_cpu_top 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

/* tests/tb_cpu_top.sv */
`timescale 1ns/1ps

module tb_cpu_top;

    localparam int MAX_ROWS  = 64;
    localparam int MAX_TESTS = 8;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = ooo_pkg::FUNCT7_ALT;
    localparam logic [6:0] F7_MUL  = ooo_pkg::FUNCT7_MULDIV;
    localparam logic [2:0] F3_ADD  = 3'b000;   // add, sub and mul
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // one instruction with the commit it must produce
    typedef struct packed {
        ooo_pkg::inst_t inst;
        ooo_pkg::areg_t rd;
        ooo_pkg::word_t value;
    } row_t;

    logic             clk;
    logic             arst_n;
    logic             inst_valid;
    ooo_pkg::inst_t   inst;
    logic             credit_return;
    ooo_pkg::commit_t commit;

    row_t             rows       [MAX_ROWS];
    string            test_name  [MAX_TESTS];
    int               test_first [MAX_TESTS];
    int               test_len   [MAX_TESTS];
    logic             test_burst [MAX_TESTS];
    int               test_err   [MAX_TESTS];
    int               num_rows = 0;
    int               num_tests = 0;
    ooo_pkg::commit_t exp_q [$];
    int               credits;
    int               seed;
    int               checks;
    int               errors;
    int               timeout_limit;
    int               cycle_count = 0;

    tb_clock i_tb_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    cpu_top i_cpu_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .credit_return (credit_return),
        .commit        (commit)
    );

    function automatic ooo_pkg::inst_t r_word(input logic [6:0] f7, input logic [2:0] f3,
                                              input ooo_pkg::areg_t rd,
                                              input ooo_pkg::areg_t rs1,
                                              input ooo_pkg::areg_t rs2);
        return {f7, rs2, rs1, f3, rd, ooo_pkg::OPC_OP};
    endfunction

    function automatic ooo_pkg::inst_t addi_word(input ooo_pkg::areg_t rd,
                                                 input ooo_pkg::areg_t rs1,
                                                 input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, ooo_pkg::OPC_OP_IMM};
    endfunction

    task automatic begin_test(input string name, input logic burst);
        test_name[num_tests]  = name;
        test_first[num_tests] = num_rows;
        test_len[num_tests]   = 0;
        test_burst[num_tests] = burst;
        test_err[num_tests]   = 0;
        num_tests++;
    endtask

    task automatic add_row(input ooo_pkg::inst_t w, input ooo_pkg::areg_t rd,
                           input ooo_pkg::word_t value);
        rows[num_rows].inst  = w;
        rows[num_rows].rd    = rd;
        rows[num_rows].value = value;
        num_rows++;
        test_len[num_tests-1]++;
    endtask

    // register state carries over from test to test
    task automatic build_table();
        begin_test("addi_imm", 1'b0);
        add_row(addi_word(5'd1, 5'd0, 12'h005), 5'd1, 32'h0000_0005);
        add_row(addi_word(5'd2, 5'd0, 12'hffd), 5'd2, 32'hffff_fffd);
        add_row(addi_word(5'd3, 5'd0, 12'h7ff), 5'd3, 32'h0000_07ff);
        add_row(addi_word(5'd4, 5'd0, 12'h800), 5'd4, 32'hffff_f800);
        add_row(addi_word(5'd5, 5'd1, 12'h064), 5'd5, 32'h0000_0069);

        begin_test("alu_ops", 1'b0);
        add_row(addi_word(5'd6, 5'd0, 12'h00c), 5'd6, 32'h0000_000c);
        add_row(addi_word(5'd7, 5'd0, 12'h00a), 5'd7, 32'h0000_000a);
        add_row(r_word(F7_BASE, F3_ADD, 5'd8, 5'd6, 5'd7), 5'd8, 32'h0000_0016);
        add_row(r_word(F7_SUB, F3_ADD, 5'd9, 5'd7, 5'd6), 5'd9, 32'hffff_fffe);
        add_row(r_word(F7_BASE, F3_AND, 5'd10, 5'd6, 5'd7), 5'd10, 32'h0000_0008);
        add_row(r_word(F7_BASE, F3_OR, 5'd11, 5'd6, 5'd7), 5'd11, 32'h0000_000e);
        add_row(r_word(F7_BASE, F3_XOR, 5'd12, 5'd6, 5'd7), 5'd12, 32'h0000_0006);
        add_row(r_word(F7_BASE, F3_SLT, 5'd13, 5'd2, 5'd1), 5'd13, 32'h0000_0001);
        add_row(r_word(F7_BASE, F3_SLT, 5'd14, 5'd1, 5'd2), 5'd14, 32'h0000_0000);
        add_row(addi_word(5'd15, 5'd0, 12'h021), 5'd15, 32'h0000_0021);
        add_row(r_word(F7_BASE, F3_SLL, 5'd16, 5'd7, 5'd15), 5'd16, 32'h0000_0014);
        add_row(r_word(F7_BASE, F3_SRL, 5'd17, 5'd4, 5'd15), 5'd17, 32'h7fff_fc00);
        add_row(addi_word(5'd18, 5'd0, 12'hfff), 5'd18, 32'hffff_ffff);
        add_row(r_word(F7_BASE, F3_SRL, 5'd19, 5'd18, 5'd18), 5'd19, 32'h0000_0001);
        add_row(r_word(F7_BASE, F3_SLL, 5'd20, 5'd1, 5'd18), 5'd20, 32'h8000_0000);

        begin_test("mul_then_independent", 1'b0);
        add_row(r_word(F7_MUL, F3_ADD, 5'd21, 5'd3, 5'd6), 5'd21, 32'h0000_5ff4);
        add_row(addi_word(5'd22, 5'd0, 12'h001), 5'd22, 32'h0000_0001);
        add_row(addi_word(5'd23, 5'd0, 12'h002), 5'd23, 32'h0000_0002);
        add_row(addi_word(5'd24, 5'd0, 12'h003), 5'd24, 32'h0000_0003);
        add_row(r_word(F7_MUL, F3_ADD, 5'd25, 5'd18, 5'd2), 5'd25, 32'h0000_0003);
        add_row(addi_word(5'd26, 5'd0, 12'hff9), 5'd26, 32'hffff_fff9);

        begin_test("dependency_chains", 1'b0);
        add_row(r_word(F7_MUL, F3_ADD, 5'd27, 5'd1, 5'd7), 5'd27, 32'h0000_0032);
        add_row(r_word(F7_BASE, F3_ADD, 5'd28, 5'd27, 5'd6), 5'd28, 32'h0000_003e);
        add_row(r_word(F7_MUL, F3_ADD, 5'd29, 5'd27, 5'd27), 5'd29, 32'h0000_09c4);
        add_row(r_word(F7_MUL, F3_ADD, 5'd29, 5'd29, 5'd29), 5'd29, 32'h005f_5e10);
        add_row(r_word(F7_MUL, F3_ADD, 5'd29, 5'd29, 5'd29), 5'd29, 32'hf26f_c100);
        add_row(r_word(F7_SUB, F3_ADD, 5'd30, 5'd28, 5'd27), 5'd30, 32'h0000_000c);
        add_row(r_word(F7_MUL, F3_ADD, 5'd31, 5'd9, 5'd17), 5'd31, 32'h0000_0800);

        begin_test("x0_writes", 1'b0);
        add_row(addi_word(5'd0, 5'd0, 12'h037), 5'd0, 32'h0000_0037);
        add_row(r_word(F7_BASE, F3_ADD, 5'd0, 5'd1, 5'd7), 5'd0, 32'h0000_000f);
        add_row(addi_word(5'd5, 5'd0, 12'h009), 5'd5, 32'h0000_0009);
        add_row(r_word(F7_BASE, F3_ADD, 5'd6, 5'd0, 5'd7), 5'd6, 32'h0000_000a);
        add_row(r_word(F7_MUL, F3_ADD, 5'd0, 5'd7, 5'd7), 5'd0, 32'h0000_0064);
        add_row(r_word(F7_BASE, F3_ADD, 5'd22, 5'd0, 5'd0), 5'd22, 32'h0000_0000);
        add_row(r_word(F7_BASE, F3_OR, 5'd23, 5'd0, 5'd0), 5'd23, 32'h0000_0000);

        begin_test("burst", 1'b1);   // no idle cycles, longer than the rob
        add_row(addi_word(5'd1, 5'd0, 12'h001), 5'd1, 32'h0000_0001);
        add_row(addi_word(5'd2, 5'd0, 12'h002), 5'd2, 32'h0000_0002);
        add_row(r_word(F7_MUL, F3_ADD, 5'd3, 5'd7, 5'd7), 5'd3, 32'h0000_0064);
        add_row(addi_word(5'd4, 5'd0, 12'h004), 5'd4, 32'h0000_0004);
        add_row(r_word(F7_MUL, F3_ADD, 5'd5, 5'd7, 5'd13), 5'd5, 32'h0000_000a);
        add_row(addi_word(5'd6, 5'd0, 12'h006), 5'd6, 32'h0000_0006);
        add_row(addi_word(5'd8, 5'd0, 12'h008), 5'd8, 32'h0000_0008);
        add_row(addi_word(5'd9, 5'd0, 12'h009), 5'd9, 32'h0000_0009);
        add_row(r_word(F7_BASE, F3_ADD, 5'd10, 5'd1, 5'd2), 5'd10, 32'h0000_0003);
        add_row(r_word(F7_BASE, F3_ADD, 5'd11, 5'd3, 5'd4), 5'd11, 32'h0000_0068);
        add_row(addi_word(5'd12, 5'd0, 12'h00c), 5'd12, 32'h0000_000c);
        add_row(r_word(F7_SUB, F3_ADD, 5'd13, 5'd5, 5'd10), 5'd13, 32'h0000_0007);
        add_row(r_word(F7_BASE, F3_XOR, 5'd14, 5'd11, 5'd12), 5'd14, 32'h0000_0064);
        add_row(addi_word(5'd15, 5'd0, 12'h00f), 5'd15, 32'h0000_000f);
    endtask

    task automatic note_error(input int t);
        test_err[t]++;
        errors++;
    endtask

    task automatic check_idle();
        checks++;
        if (commit.valid !== 1'b0) begin
            $display("commit.valid went high before any instruction was sent");
            note_error(0);
        end
        if (credit_return !== 1'b0) begin
            $display("credit_return went high before any instruction was sent");
            note_error(0);
        end
    endtask

    // called once per cycle on the falling edge
    task automatic sample_outputs(input int t);
        ooo_pkg::commit_t exp;
        if (credit_return) begin
            credits++;
            if (credits > ooo_pkg::IQ_DEPTH) begin
                $display("%s: more credits returned than instructions sent", test_name[t]);
                note_error(t);
            end
        end
        if (commit.valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: commit to x%0d arrived with no instruction outstanding",
                         test_name[t], commit.rd);
                note_error(t);
            end else begin
                exp = exp_q.pop_front();
                checks += 2;
                if (commit.rd !== exp.rd) begin
                    $display("FAILED %s: rd expected %0d actual %0d",
                             test_name[t], exp.rd, commit.rd);
                    note_error(t);
                end
                if (commit.value !== exp.value) begin
                    $display("FAILED %s: x%0d expected %h actual %h",
                             test_name[t], exp.rd, exp.value, commit.value);
                    note_error(t);
                end
            end
        end
    endtask

    task automatic run_test(input int t);
        int               sent;
        int               idx;
        ooo_pkg::commit_t e;
        sent = 0;
        while (sent < test_len[t] || exp_q.size() != 0) begin
            @(negedge clk);
            sample_outputs(t);
            inst_valid = 1'b0;
            if (sent < test_len[t] && credits > 0) begin
                if (test_burst[t] || ($random(seed) & 3) != 0) begin   // ~1 in 4 idle
                    idx        = test_first[t] + sent;
                    inst_valid = 1'b1;
                    inst       = rows[idx].inst;
                    e.valid    = 1'b1;
                    e.rd       = rows[idx].rd;
                    e.value    = rows[idx].value;
                    exp_q.push_back(e);
                    credits--;
                    sent++;
                end
            end
        end
        checks++;
        if (credits != ooo_pkg::IQ_DEPTH) begin
            $display("FAILED %s: credits expected %0d actual %0d",
                     test_name[t], ooo_pkg::IQ_DEPTH, credits);
            note_error(t);
        end
        $display("test %0d %s: %0d instructions, %0d errors",
                 t + 1, test_name[t], test_len[t], test_err[t]);
    endtask

    initial begin
        inst_valid = 1'b0;
        inst       = '0;
        seed       = 99;
        credits    = ooo_pkg::IQ_DEPTH;
        checks     = 0;
        errors     = 0;
        build_table();
        timeout_limit = num_rows * (ooo_pkg::MUL_STAGES + 10) + 100;

        repeat (6) @(negedge clk) check_idle();   // through reset and a few idle cycles
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end

        $display("%0d tests, %0d instructions, %0d checks, %0d errors",
                 num_tests, num_rows, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= timeout_limit) begin
                $display("timeout after %0d cycles, commits stopped arriving", cycle_count);
                $display("Simulation finished: FAIL");
                $finish;
            end
        end
    end

endmodule
